/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= memSysTb
FILELIST  ?= memSys.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/memSysTb.sv */
`include "memSys_consts.svh"

`default_nettype none

module memSysTb import memPkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int opBudget       = 87;
    localparam int watchdogCycles = opBudget * (`UNCACHED_LAT + 2) + 20;
    localparam int memBits        = $clog2(`MEM_WORDS);
    localparam int lineBits       = $clog2(`CACHE_LINES);
    localparam logic [31:0] kseg1Base = 32'hA000_0000;

    logic      Clk;
    logic      rstN;
    logic      flush;
    exBundle_t exIn;
    logic      stall;
    wbBundle_t wbOut;

    // Reference model of memory, cache residency and the last write-back.
    logic [31:0] shadowMem [`MEM_WORDS];
    logic        lineValid [`CACHE_LINES];
    logic [29:0] lineWord  [`CACHE_LINES];
    wbBundle_t   curWb;
    logic [31:0] pcNext;
    integer      seed;

    logic      chkValid;
    wbBundle_t expWb;
    int        latExp;
    int        latGot;

    tbClock u_clock (
        .Clk  (Clk),
        .rstN (rstN)
    );

    memSys u_dut (
        .Clk   (Clk),
        .rstN  (rstN),
        .flush (flush),
        .exIn  (exIn),
        .stall (stall),
        .wbOut (wbOut)
    );

    task automatic failValue(input string sigName, input logic [69:0] expVal,
                             input logic [69:0] gotVal);
        $display("FAIL at %0t ns: %s expected %0h, got %0h", $time, sigName, expVal, gotVal);
        $display("Finished with errors");
        $fatal(1, "check failed");
    endtask

    // ========================================================================
    // Checks, one edge after each accepted instruction
    // ========================================================================

    wbMatches: assert property (@(posedge Clk) disable iff (!rstN)
        chkValid |-> (wbOut == expWb))
        else failValue("wbOut", $sampled(expWb), $sampled(wbOut));

    stallCycles: assert property (@(posedge Clk) disable iff (!rstN)
        chkValid |-> (latGot == latExp))
        else failValue("stall cycles", 70'($sampled(latExp)), 70'($sampled(latGot)));

    flushClears: assert property (@(posedge Clk) disable iff (!rstN)
        flush |=> !wbOut.regWrite)
        else failValue("wbOut.regWrite", 70'(0), 70'($sampled(wbOut.regWrite)));

    initial begin
        #(watchdogCycles * 100);
        $display("Timeout: the run did not finish within %0d clock periods.", watchdogCycles);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    // ========================================================================
    // Reference rules
    // ========================================================================

    function automatic bit isLoadOp(input memOp_t op);
        return op inside {opLw, opLh, opLhu, opLb, opLbu, opLwl, opLwr};
    endfunction

    function automatic bit isStoreOp(input memOp_t op);
        return op inside {opSw, opSh, opSb, opSwl, opSwr};
    endfunction

    // Byte lane i of the word takes byte src of rt, or keeps its old value.
    function automatic logic [31:0] storeModel(input memOp_t op, input logic [1:0] offset,
                                               input logic [31:0] rt, input logic [31:0] old);
        logic [31:0] w;
        int          src;
        int          o;
        w = old;
        o = int'(offset);
        for (int i = 0; i < 4; i++) begin
            src = -1;
            case (op)
                opSw:  src = i;
                opSh:  src = ((i / 2) == int'(offset[1])) ? (i % 2) : -1;
                opSb:  src = (i == o) ? 0 : -1;
                opSwl: src = (i <= o) ? (i + 3 - o) : -1;
                opSwr: src = (i >= o) ? (i - o) : -1;
                default: src = -1;
            endcase
            if (src >= 0) begin
                w[8*i +: 8] = rt[8*src +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] loadModel(input memOp_t op, input logic [1:0] offset,
                                              input logic [31:0] word, input logic [31:0] rt);
        logic [31:0] r;
        logic [7:0]  b;
        logic [15:0] h;
        int          o;
        o = int'(offset);
        b = word[8*o +: 8];
        h = offset[1] ? word[31:16] : word[15:0];
        r = word;
        case (op)
            opLb:  r = {{24{b[7]}}, b};
            opLbu: r = {24'h000000, b};
            opLh:  r = {{16{h[15]}}, h};
            opLhu: r = {16'h0000, h};
            opLwl: begin
                r = rt;
                for (int i = 0; i <= o; i++) begin
                    r[8*(3 - o + i) +: 8] = word[8*i +: 8];
                end
            end
            opLwr: begin
                r = rt;
                for (int i = o; i < 4; i++) begin
                    r[8*(i - o) +: 8] = word[8*i +: 8];
                end
            end
            default: r = word;
        endcase
        return r;
    endfunction

    function automatic exBundle_t makeEx(input memOp_t op, input logic [31:0] addr,
                                         input logic [31:0] sd, input logic [4:0] rtId,
                                         input logic [4:0] rd);
        exBundle_t e;
        e.op        = op;
        e.addr      = addr;
        e.storeData = sd;
        e.rtId      = rtId;
        e.regWrite  = !isStoreOp(op);
        e.regNum    = rd;
        e.pc        = pcNext;
        return e;
    endfunction

    // ========================================================================
    // Driving
    // ========================================================================

    // Presents e and returns on the edge that accepts it.
    task automatic issue(input exBundle_t e, output int stalls);
        logic held;
        stalls = 0;
        exIn <= e;
        forever begin
            @(negedge Clk);
            held = stall;
            @(posedge Clk);
            if (!held) begin
                break;
            end
            stalls++;
        end
    endtask

    task automatic runOp(input memOp_t op, input logic [31:0] addr, input logic [31:0] sd,
                         input logic [4:0] rtId, input logic [4:0] rd);
        exBundle_t             e;
        wbBundle_t             nextWb;
        logic [31:0]           rt;
        logic [31:0]           word;
        logic [memBits-1:0]    memIdx;
        logic [lineBits-1:0]   lineIdx;
        int                    expStalls;
        int                    stalls;
        e       = makeEx(op, addr, sd, rtId, rd);
        memIdx  = addr[2 +: memBits];
        lineIdx = addr[2 +: lineBits];
        word    = shadowMem[memIdx];
        rt = (curWb.regWrite && curWb.regId != 5'd0 && curWb.regId == rtId) ? curWb.data : sd;
        expStalls = 0;
        if (isLoadOp(op)) begin
            if (addr >= kseg1Base && addr <= 32'hBFFF_FFFF) begin
                expStalls = `UNCACHED_LAT;
            end else if (!(lineValid[lineIdx] && lineWord[lineIdx] == addr[31:2])) begin
                expStalls          = `REFILL_LAT;
                lineValid[lineIdx] = 1'b1;
                lineWord[lineIdx]  = addr[31:2];
            end
        end
        if (isStoreOp(op)) begin
            shadowMem[memIdx] = storeModel(op, addr[1:0], rt, word);
        end
        nextWb.regWrite = e.regWrite;
        nextWb.regId    = rd;
        nextWb.data     = isLoadOp(op) ? loadModel(op, addr[1:0], word, rt) : addr;
        nextWb.pc       = pcNext;
        issue(e, stalls);
        curWb    = nextWb;
        pcNext   = pcNext + 32'd4;
        expWb    <= nextWb;
        chkValid <= 1'b1;
        latExp   <= expStalls;
        latGot   <= stalls;
    endtask

    initial begin
        logic [31:0] base;
        logic [31:0] val;
        logic [1:0]  off;
        seed     = 32'hbfa0_1854;
        exIn     = '0;
        flush    = 1'b0;
        chkValid = 1'b0;
        expWb    = '0;
        curWb    = '0;
        latExp   = 0;
        latGot   = 0;
        pcNext   = 32'h0040_0000;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadowMem[i] = 32'h0000_0000;
        end
        for (int i = 0; i < `CACHE_LINES; i++) begin
            lineValid[i] = 1'b0;
            lineWord[i]  = '0;
        end
        wait (rstN === 1'b1);
        @(posedge Clk);

        // Word round trip.
        for (int i = 0; i < 4; i++) begin
            base = 32'h0000_0100 + 32'(i * 16);
            runOp(opSw, base, $random(seed), 5'd0, 5'd0);
            runOp(opLw, base, 32'h0, 5'd0, 5'd8);
        end

        // Subword loads at every offset, then byte and halfword stores.
        base = 32'h0000_0200;
        val  = $random(seed) | 32'h8000_0080;
        runOp(opSw, base, val, 5'd0, 5'd0);
        for (int o = 0; o < 4; o++) begin
            runOp(opLb, base + 32'(o), 32'h0, 5'd0, 5'd9);
            runOp(opLbu, base + 32'(o), 32'h0, 5'd0, 5'd9);
            runOp(opLh, base + 32'(o), 32'h0, 5'd0, 5'd10);
            runOp(opLhu, base + 32'(o), 32'h0, 5'd0, 5'd10);
        end
        runOp(opSb, base + 32'd1, $random(seed), 5'd0, 5'd0);
        runOp(opSh, base + 32'd2, $random(seed), 5'd0, 5'd0);
        runOp(opLw, base, 32'h0, 5'd0, 5'd11);

        // Unaligned pairs; register 12 is carried through forwarding.
        for (int k = 0; k < 6; k++) begin
            base = 32'h0000_0400 + 32'(k * 4);
            runOp(opSw, base, $random(seed), 5'd0, 5'd0);
            runOp(opNone, $random(seed), 32'h0, 5'd0, 5'd12);
            off = 2'($random(seed));
            runOp(opLwl, base + 32'(off), 32'h0, 5'd12, 5'd12);
            off = 2'($random(seed));
            runOp(opLwr, base + 32'(off), 32'h0, 5'd12, 5'd12);
            off = 2'($random(seed));
            runOp(opSwl, base + 32'h100 + 32'(off), 32'h0, 5'd12, 5'd0);
            off = 2'($random(seed));
            runOp(opSwr, base + 32'h100 + 32'(off), $random(seed), 5'd3, 5'd0);
            runOp(opLw, base + 32'h100, 32'h0, 5'd0, 5'd13);
        end

        // Latency: miss, hit, kseg1 twice, a store, then a conflicting tag.
        base = 32'h0000_0600;
        runOp(opLw, base, 32'h0, 5'd0, 5'd14);
        runOp(opLw, base, 32'h0, 5'd0, 5'd14);
        runOp(opLw, kseg1Base | base, 32'h0, 5'd0, 5'd15);
        runOp(opLw, kseg1Base | base, 32'h0, 5'd0, 5'd15);
        runOp(opSw, base + 32'd4, $random(seed), 5'd0, 5'd0);
        runOp(opLw, base + 32'h40, 32'h0, 5'd0, 5'd16);
        runOp(opLw, base, 32'h0, 5'd0, 5'd16);

        // Forwarding; register 0 never forwards.
        runOp(opNone, 32'h1357_9BDF, 32'h0, 5'd0, 5'd7);
        runOp(opSw, 32'h0000_0700, $random(seed), 5'd7, 5'd0);
        runOp(opLw, 32'h0000_0700, 32'h0, 5'd0, 5'd17);
        runOp(opNone, 32'h2468_ACE0, 32'h0, 5'd0, 5'd0);
        runOp(opSw, 32'h0000_0704, $random(seed), 5'd0, 5'd0);
        runOp(opLw, 32'h0000_0704, 32'h0, 5'd0, 5'd18);

        // Flush on the cycle the refill would land, so the line is never filled.
        base = 32'h0000_0300;
        exIn <= makeEx(opLw, base, 32'h0, 5'd0, 5'd19);
        repeat (`REFILL_LAT - 1) @(posedge Clk);
        flush <= 1'b1;
        @(posedge Clk);
        flush <= 1'b0;
        curWb = '0;
        expWb <= '0;
        runOp(opNone, 32'h0000_0055, 32'h0, 5'd0, 5'd20);
        runOp(opLw, base, 32'h0, 5'd0, 5'd19);
        runOp(opNone, 32'h0000_00AA, 32'h0, 5'd0, 5'd20);

        repeat (2) @(posedge Clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`default_nettype none

module tbClock (
    output logic Clk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 1ns;

    // 100 ns period.
    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge Clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

/* memSys.f */
+incdir+verilog
verilog/memPkg.sv
verilog/storeAlign.sv
verilog/loadAlign.sv
verilog/memStage.sv
verilog/dataCache.sv
verilog/memSys.sv
dv/tbClock.sv
dv/memSysTb.sv

/* verilog/dataCache.sv */
`include "memSys_consts.svh"

`default_nettype none

module dataCache import memPkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        flush,
    input  cacheReq_t   req,
    output logic [31:0] rdata,
    output logic        ready
);

    localparam int idxBits     = $clog2(`CACHE_LINES);
    localparam int tagBits     = 30 - idxBits;
    localparam int memAddrBits = $clog2(`MEM_WORDS);
    localparam int maxLat      = (`UNCACHED_LAT > `REFILL_LAT) ? `UNCACHED_LAT : `REFILL_LAT;
    localparam int cntBits     = $clog2(maxLat + 1);

    localparam logic [cntBits-1:0] refillLast   = cntBits'(`REFILL_LAT - 1);
    localparam logic [cntBits-1:0] uncachedDone = cntBits'(`UNCACHED_LAT);

    logic               validArr [`CACHE_LINES];
    logic [tagBits-1:0] tagArr   [`CACHE_LINES];
    logic [31:0]        dataArr  [`CACHE_LINES];
    logic [31:0]        memArr   [`MEM_WORDS];

    logic [idxBits-1:0]     idx;
    logic [tagBits-1:0]     tag;
    logic [memAddrBits-1:0] wordIdx;
    logic                   uncached;
    logic                   hit;
    logic [cntBits-1:0]     waitCnt;
    logic                   fillNow;

    assign idx     = req.addr[2 +: idxBits];
    assign tag     = req.addr[31 -: tagBits];
    assign wordIdx = req.addr[2 +: memAddrBits];

    // kseg1 is 0xA000_0000 to 0xBFFF_FFFF.
    assign uncached = (req.addr[31:29] == 3'b101);
    assign hit      = validArr[idx] && (tagArr[idx] == tag);

    always_comb begin
        if (!req.read) begin
            ready = 1'b1;
        end else if (uncached) begin
            ready = (waitCnt == uncachedDone);
        end else begin
            ready = hit;
        end
    end

    assign rdata = uncached ? memArr[wordIdx] : dataArr[idx];

    // The fill lands on the last low cycle so the next cycle is a plain hit.
    assign fillNow = req.read && !uncached && !hit && (waitCnt == refillLast) && !flush;

    // ========================================================================
    // Latency counter, shared by refills and uncached loads
    // ========================================================================

    always_ff @(posedge Clk) begin
        if (!rstN || flush) begin
            waitCnt <= '0;
        end else if (req.read && !ready) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            waitCnt <= '0;
        end
    end

    // ========================================================================
    // Tag and data store
    // ========================================================================

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                validArr[i] <= 1'b0;
            end
        end else if (fillNow) begin
            validArr[idx] <= 1'b1;
            tagArr[idx]   <= tag;
            dataArr[idx]  <= memArr[wordIdx];
        end else if (req.write && !uncached && hit) begin
            // Write-through; only a resident line is updated.
            for (int b = 0; b < 4; b++) begin
                if (req.byteEn[b]) begin
                    dataArr[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // Backing store. Stores never wait, they retire at this edge.
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                memArr[i] <= 32'h0000_0000;
            end
        end else if (req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byteEn[b]) begin
                    memArr[wordIdx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    wordAligned: assert property (@(posedge Clk) disable iff (!rstN)
        (req.read || req.write) |-> (req.addr[1:0] == 2'b00))
        else $error("cache request address not word aligned");

    noReadWrite: assert property (@(posedge Clk) disable iff (!rstN)
        !(req.read && req.write))
        else $error("read and write requested together");

endmodule

`default_nettype wire

/* verilog/loadAlign.sv */
`default_nettype none

module loadAlign import memPkg::*; (
    input  memOp_t      op,
    input  logic [1:0]  offset,
    input  logic [31:0] word,
    input  logic [31:0] rtValue,
    output logic [31:0] result
);

    logic [15:0] half;
    logic [7:0]  byteVal;
    logic [4:0]  leftShift;
    logic [4:0]  rightShift;

    assign half       = offset[1] ? word[31:16] : word[15:0];
    assign byteVal    = word[{offset, 3'b000} +: 8];
    assign leftShift  = {~offset, 3'b000};
    assign rightShift = {offset, 3'b000};

    always_comb begin
        result = word;
        case (op)
            opLh: begin
                result = {{16{half[15]}}, half};
            end
            opLhu: begin
                result = {16'h0000, half};
            end
            opLb: begin
                result = {{24{byteVal[7]}}, byteVal};
            end
            opLbu: begin
                result = {24'h000000, byteVal};
            end
            opLwl: begin
                // Lanes offset..0 go to the top of rt, the rest of rt stays.
                result = (word << leftShift)
                       | (rtValue & ~(32'hFFFF_FFFF << leftShift));
            end
            opLwr: begin
                // Lanes offset..3 go to the bottom of rt.
                result = (word >> rightShift)
                       | (rtValue & ~(32'hFFFF_FFFF >> rightShift));
            end
            default: begin
                result = word;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/memPkg.sv */
`default_nettype none

package memPkg;

    // Memory opcodes as decoded by execute.
    typedef enum logic [3:0] {
        opNone,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opLwl,
        opLwr,
        opSw,
        opSh,
        opSb,
        opSwl,
        opSwr
    } memOp_t;

    // Execute to memory. For non-memory ops addr holds the ALU result.
    typedef struct packed {
        memOp_t      op;
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [4:0]  rtId;
        logic        regWrite;
        logic [4:0]  regNum;
        logic [31:0] pc;
    } exBundle_t;

    // Memory to write-back.
    typedef struct packed {
        logic        regWrite;
        logic [4:0]  regId;
        logic [31:0] data;
        logic [31:0] pc;
    } wbBundle_t;

    // Request to the data cache, word address with byte lanes.
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byteEn;
    } cacheReq_t;

endpackage

`default_nettype wire

/* verilog/memStage.sv */
`default_nettype none

module memStage import memPkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        flush,
    input  exBundle_t   exIn,
    input  logic [31:0] rdata,
    input  logic        ready,
    output cacheReq_t   req,
    output logic        stall,
    output wbBundle_t   wbOut
);

    logic        fwdHit;
    logic [31:0] rtValue;
    logic        isLoad;
    logic        isStore;
    logic [31:0] storeWord;
    logic [3:0]  storeEn;
    logic [31:0] loadResult;
    logic [31:0] wbData;

    // ========================================================================
    // Forwarding from the previous write-back
    // ========================================================================

    assign fwdHit  = wbOut.regWrite && (wbOut.regId != 5'd0) && (wbOut.regId == exIn.rtId);
    assign rtValue = fwdHit ? wbOut.data : exIn.storeData;

    assign isLoad  = exIn.op inside {opLw, opLh, opLhu, opLb, opLbu, opLwl, opLwr};
    assign isStore = exIn.op inside {opSw, opSh, opSb, opSwl, opSwr};

    // ========================================================================
    // Cache request
    // ========================================================================

    storeAlign u_storeAlign (
        .op      (exIn.op),
        .offset  (exIn.addr[1:0]),
        .rtValue (rtValue),
        .wdata   (storeWord),
        .byteEn  (storeEn)
    );

    always_comb begin
        req.read   = isLoad;
        req.write  = isStore;
        req.addr   = {exIn.addr[31:2], 2'b00};
        req.wdata  = storeWord;
        req.byteEn = isStore ? storeEn : 4'b0000;
    end

    // Stores always complete at once, so only a waiting load holds the pipe.
    assign stall = isLoad && !ready;

    // ========================================================================
    // Load data and write-back register
    // ========================================================================

    loadAlign u_loadAlign (
        .op      (exIn.op),
        .offset  (exIn.addr[1:0]),
        .word    (rdata),
        .rtValue (rtValue),
        .result  (loadResult)
    );

    assign wbData = isLoad ? loadResult : exIn.addr;

    always_ff @(posedge Clk) begin
        if (!rstN || flush) begin
            wbOut <= '0;
        end else if (!stall) begin
            wbOut.regWrite <= exIn.regWrite;
            wbOut.regId    <= exIn.regNum;
            wbOut.data     <= wbData;
            wbOut.pc       <= exIn.pc;
        end
    end

    // Execute must hold its bundle while a load waits on the cache.
    exInHeldInStall: assert property (@(posedge Clk) disable iff (!rstN)
        (stall && !flush) |=> $stable(exIn))
        else $error("exIn changed during a stall");

endmodule

`default_nettype wire

/* verilog/memSys.sv */
`default_nettype none

module memSys import memPkg::*; (
    input  logic      Clk,
    input  logic      rstN,
    input  logic      flush,
    input  exBundle_t exIn,
    output logic      stall,
    output wbBundle_t wbOut
);

    cacheReq_t   req;
    logic [31:0] rdata;
    logic        ready;

    memStage u_stage (
        .Clk   (Clk),
        .rstN  (rstN),
        .flush (flush),
        .exIn  (exIn),
        .rdata (rdata),
        .ready (ready),
        .req   (req),
        .stall (stall),
        .wbOut (wbOut)
    );

    dataCache u_cache (
        .Clk   (Clk),
        .rstN  (rstN),
        .flush (flush),
        .req   (req),
        .rdata (rdata),
        .ready (ready)
    );

endmodule

`default_nettype wire

/* verilog/memSys_consts.svh */
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

`default_nettype none

// Direct-mapped, one word per line.
`define CACHE_LINES 16

// Backing store depth in words. Addresses wrap modulo this depth.
`define MEM_WORDS 1024

// Cycles that ready stays low for a cached miss.
`define REFILL_LAT 4

// Cycles that ready stays low for a kseg1 load.
`define UNCACHED_LAT 6

`default_nettype wire

`endif

/* verilog/storeAlign.sv */
`default_nettype none

module storeAlign import memPkg::*; (
    input  memOp_t      op,
    input  logic [1:0]  offset,
    input  logic [31:0] rtValue,
    output logic [31:0] wdata,
    output logic [3:0]  byteEn
);

    // Little-endian lanes. Lane n holds address offset n.
    always_comb begin
        wdata  = rtValue;
        byteEn = 4'b0000;
        case (op)
            opSw: begin
                byteEn = 4'b1111;
            end
            opSh: begin
                wdata  = {rtValue[15:0], rtValue[15:0]};
                byteEn = offset[1] ? 4'b1100 : 4'b0011;
            end
            opSb: begin
                wdata  = {4{rtValue[7:0]}};
                byteEn = 4'b0001 << offset;
            end
            opSwl: begin
                // High bytes of rt land in lanes offset down to 0.
                wdata  = rtValue >> {~offset, 3'b000};
                byteEn = 4'b1111 >> ~offset;
            end
            opSwr: begin
                wdata  = rtValue << {offset, 3'b000};
                byteEn = 4'b1111 << offset;
            end
            default: begin
                byteEn = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire
